// File: soc_defs.svh
// ------------------------------
// Bus widths, region codes and register offsets of the peripheral fabric
// Include wherever one of these macros is needed
// ------------------------------
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define SOC_ADDR_W    16   // Byte address
`define SOC_DATA_W    32
`define SOC_STRB_W    4
`define SOC_RAM_WORDS 256
`define SOC_IRQ_N     4    // Peripheral interrupt lines

// Region codes in address bits 15 to 12
`define SOC_REG_RAM   4'h0
`define SOC_REG_TIMER 4'h1
`define SOC_REG_IRQ   4'h2

// Machine timer register offsets
`define SOC_TMR_TIME_LO 12'h000
`define SOC_TMR_TIME_HI 12'h004
`define SOC_TMR_CMP_LO  12'h008
`define SOC_TMR_CMP_HI  12'h00C

// Interrupt enable block offsets
`define SOC_IRQ_PEND 12'h000
`define SOC_IRQ_MEN  12'h004
`define SOC_IRQ_SEN  12'h008

`endif

// File: soc_pkg.sv
// ------------------------------
// Types shared by the fabric and its targets
// Ports name them by scope, bodies import the package
// ------------------------------
`include "soc_defs.svh"

package soc_pkg;

   typedef logic [`SOC_ADDR_W-1:0] addr_t;
   typedef logic [`SOC_DATA_W-1:0] data_t;
   typedef logic [`SOC_STRB_W-1:0] strb_t;   // All zero marks a read
   typedef logic [`SOC_IRQ_N-1:0]  irq_t;

   // Target selected by the upper address bits
   typedef enum logic [1:0] {
      REGION_RAM   = 2'd0,
      REGION_TIMER = 2'd1,
      REGION_IRQ   = 2'd2,
      REGION_NONE  = 2'd3
   } region_e;

   // CPU side request, 52 bits
   typedef struct packed {
      addr_t addr;
      strb_t strb;
      data_t wdata;
   } soc_req_t;

   // Response back to the CPU side, 33 bits
   typedef struct packed {
      data_t rdata;
      logic  err;   // Unmapped address
   } soc_rsp_t;

endpackage

// File: soc_addr_decode.sv
// ------------------------------
// Single master address decoder with one response stage
// Raises one target accept per handshake and returns its data
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_addr_decode (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              req_valid_i,
   input  soc_pkg::soc_req_t req_i,
   output logic              req_ready_o,
   output logic              rsp_valid_o,
   output soc_pkg::soc_rsp_t rsp_o,
   input  logic              rsp_ready_i,
   output logic              ram_acc_o,
   output logic              tmr_acc_o,
   output logic              irq_acc_o,
   input  soc_pkg::data_t    ram_rdata_i,
   input  soc_pkg::data_t    tmr_rdata_i,
   input  soc_pkg::data_t    irq_rdata_i
);
   import soc_pkg::*;

   region_e region_d;
   region_e region_q;   // Region of the response in flight
   logic    accept;
   logic    wr_q;
   logic    rsp_valid_q;
   data_t   rdata_sel;

   always_comb begin
      case (req_i.addr[`SOC_ADDR_W-1 -: 4])
         `SOC_REG_RAM:   region_d = REGION_RAM;
         `SOC_REG_TIMER: region_d = REGION_TIMER;
         `SOC_REG_IRQ:   region_d = REGION_IRQ;
         default:        region_d = REGION_NONE;
      endcase
   end

   // Free response slot, or the current one leaves this cycle
   assign req_ready_o = !rsp_valid_q || rsp_ready_i;
   assign accept      = req_valid_i && req_ready_o;

   assign ram_acc_o = accept && (region_d == REGION_RAM);
   assign tmr_acc_o = accept && (region_d == REGION_TIMER);
   assign irq_acc_o = accept && (region_d == REGION_IRQ);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rsp_valid_q <= 1'b0;
         region_q    <= REGION_RAM;
         wr_q        <= 1'b1;   // Keeps rsp_o at zero until the first request
      end else begin
         if (accept) begin
            rsp_valid_q <= 1'b1;
            region_q    <= region_d;
            wr_q        <= (req_i.strb != '0);
         end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
         end
      end
   end

   always_comb begin
      case (region_q)
         REGION_RAM:   rdata_sel = ram_rdata_i;
         REGION_TIMER: rdata_sel = tmr_rdata_i;
         REGION_IRQ:   rdata_sel = irq_rdata_i;
         default:      rdata_sel = '0;
      endcase
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o.rdata = wr_q ? '0 : rdata_sel;   // Writes answer with zero
   assign rsp_o.err   = (region_q == REGION_NONE);

   acc_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({ram_acc_o, tmr_acc_o, irq_acc_o}))
      else $error("More than one target accepted the same request");

   // Targets must not change their read data while the response stalls
   rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
      else $error("Response changed under back-pressure");

endmodule

// File: soc_bram.sv
// ------------------------------
// Scratch RAM with byte strobes and a registered read port
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_bram (
   input  logic              clk_i,
   input  logic              acc_i,
   input  soc_pkg::soc_req_t req_i,
   output soc_pkg::data_t    rdata_o
);
   import soc_pkg::*;

   localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

   data_t            mem [`SOC_RAM_WORDS];
   logic [IDX_W-1:0] idx;
   logic             is_read;

   // Word index, upper offset bits alias onto the same words
   assign idx     = req_i.addr[IDX_W+1:2];
   assign is_read = (req_i.strb == '0);

   always_ff @(posedge clk_i) begin
      if (acc_i) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (req_i.strb[b]) begin
               mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Read data stays put until the next read
   always_ff @(posedge clk_i) begin
      if (acc_i && is_read) begin
         rdata_o <= mem[idx];
      end
   end

endmodule

// File: soc_timer.sv
// ------------------------------
// Machine timer with 64-bit time and compare
// Interrupt while time is at or past compare
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_timer (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              acc_i,
   input  soc_pkg::soc_req_t req_i,
   output soc_pkg::data_t    rdata_o,
   output logic              timer_irq_o
);
   import soc_pkg::*;

   localparam int TIME_W = 2 * `SOC_DATA_W;

   logic [TIME_W-1:0] time_q;
   logic [TIME_W-1:0] cmp_q;
   logic [11:0]       off;
   logic              wr_en;
   data_t             rdata_d;

   assign off   = req_i.addr[11:0];
   assign wr_en = acc_i && (req_i.strb != '0);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         time_q      <= '0;
         cmp_q       <= '1;   // No interrupt until software sets compare
         timer_irq_o <= 1'b0;
      end else begin
         time_q      <= time_q + 1'b1;
         timer_irq_o <= (time_q >= cmp_q);
         if (wr_en) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
               if (req_i.strb[b] && off == `SOC_TMR_CMP_LO) begin
                  cmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
               if (req_i.strb[b] && off == `SOC_TMR_CMP_HI) begin
                  cmp_q[`SOC_DATA_W + 8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_comb begin
      case (off)
         `SOC_TMR_TIME_LO: rdata_d = time_q[`SOC_DATA_W-1:0];
         `SOC_TMR_TIME_HI: rdata_d = time_q[TIME_W-1:`SOC_DATA_W];
         `SOC_TMR_CMP_LO:  rdata_d = cmp_q[`SOC_DATA_W-1:0];
         `SOC_TMR_CMP_HI:  rdata_d = cmp_q[TIME_W-1:`SOC_DATA_W];
         default:          rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (acc_i) rdata_o <= rdata_d;   // Captured on the accept edge
   end

   time_mono_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      time_q >= $past(time_q))
      else $error("Time counter decreased");

endmodule

// File: soc_irq_ctrl.sv
// ------------------------------
// Interrupt enables for machine and supervisor level
// Masks peripheral lines into meip and seip
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module soc_irq_ctrl (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              acc_i,
   input  soc_pkg::soc_req_t req_i,
   input  soc_pkg::irq_t     irq_src_i,
   output soc_pkg::data_t    rdata_o,
   output logic              meip_o,
   output logic              seip_o
);
   import soc_pkg::*;

   irq_t        men_q;
   irq_t        sen_q;
   logic [11:0] off;
   logic        wr_lo;   // Low byte written
   data_t       rdata_d;

   assign off   = req_i.addr[11:0];
   assign wr_lo = acc_i && req_i.strb[0];

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         men_q <= '0;
         sen_q <= '0;
      end else if (wr_lo) begin
         if (off == `SOC_IRQ_MEN) men_q <= req_i.wdata[`SOC_IRQ_N-1:0];
         if (off == `SOC_IRQ_SEN) sen_q <= req_i.wdata[`SOC_IRQ_N-1:0];
      end
   end

   // Pending is read only and shows the raw lines
   always_comb begin
      case (off)
         `SOC_IRQ_PEND: rdata_d = data_t'(irq_src_i);
         `SOC_IRQ_MEN:  rdata_d = data_t'(men_q);
         `SOC_IRQ_SEN:  rdata_d = data_t'(sen_q);
         default:       rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (acc_i) begin
         rdata_o <= rdata_d;
      end
   end

   // Level sensitive, no latching of sources
   assign meip_o = |(irq_src_i & men_q);
   assign seip_o = |(irq_src_i & sen_q);

endmodule

// File: soc_fabric_top.sv
// ------------------------------
// Peripheral fabric top, one CPU request port
// Decoder in front of RAM, timer and interrupt enables
// ------------------------------
`timescale 1ns/1ns

module soc_fabric_top (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              req_valid_i,
   input  soc_pkg::soc_req_t req_i,
   output logic              req_ready_o,
   output logic              rsp_valid_o,
   output soc_pkg::soc_rsp_t rsp_o,
   input  logic              rsp_ready_i,
   input  soc_pkg::irq_t     irq_src_i,
   output logic              timer_irq_o,
   output logic              meip_o,
   output logic              seip_o
);
   import soc_pkg::*;

   logic  ram_acc;
   logic  tmr_acc;
   logic  irq_acc;
   data_t ram_rdata;
   data_t tmr_rdata;
   data_t irq_rdata;

   soc_addr_decode soc_addr_decode_inst (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .req_valid_i ( req_valid_i ),
      .req_i       ( req_i       ),
      .req_ready_o ( req_ready_o ),
      .rsp_valid_o ( rsp_valid_o ),
      .rsp_o       ( rsp_o       ),
      .rsp_ready_i ( rsp_ready_i ),
      .ram_acc_o   ( ram_acc     ),
      .tmr_acc_o   ( tmr_acc     ),
      .irq_acc_o   ( irq_acc     ),
      .ram_rdata_i ( ram_rdata   ),
      .tmr_rdata_i ( tmr_rdata   ),
      .irq_rdata_i ( irq_rdata   )
   );

   soc_bram soc_bram_inst (
      .clk_i   ( clk_i     ),
      .acc_i   ( ram_acc   ),
      .req_i   ( req_i     ),
      .rdata_o ( ram_rdata )
   );

   soc_timer soc_timer_inst (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .acc_i       ( tmr_acc     ),
      .req_i       ( req_i       ),
      .rdata_o     ( tmr_rdata   ),
      .timer_irq_o ( timer_irq_o )
   );

   // Peripheral lines bypass the decoder
   soc_irq_ctrl soc_irq_ctrl_inst (
      .clk_i     ( clk_i     ),
      .rst_ni    ( rst_ni    ),
      .acc_i     ( irq_acc   ),
      .req_i     ( req_i     ),
      .irq_src_i ( irq_src_i ),
      .rdata_o   ( irq_rdata ),
      .meip_o    ( meip_o    ),
      .seip_o    ( seip_o    )
   );

endmodule

// File: tb_soc_checker.sv
// ------------------------------
// Response and interrupt checker for the fabric testbench
// Keeps a RAM model and an in-order queue of expected responses
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module tb_soc_checker (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              req_valid_i,
   input  soc_pkg::soc_req_t req_i,
   input  logic              req_ready_i,
   input  logic              rsp_valid_i,
   input  soc_pkg::soc_rsp_t rsp_i,
   input  logic              rsp_ready_i,
   input  logic              timer_irq_i,
   input  logic              meip_i,
   input  logic              seip_i,
   input  soc_pkg::data_t    exp_rdata_i,
   input  logic              exp_err_i,
   input  logic              exp_meip_i,
   input  logic              exp_seip_i,
   input  logic              exp_tirq_i,
   input  logic [3:0]        chk_i,        // Data, RAM model, time order, irq levels
   input  logic              test_end_i,
   input  int                test_id_i,
   output int                pending_o,
   output int                errors_o,
   output int                tests_o,
   output int                failed_o
);
   import soc_pkg::*;

   typedef struct {
      data_t      rdata;
      logic       err;
      logic [3:0] chk;
      logic       known;
   } exp_t;

   exp_t       exp_q[$];
   data_t      ram_m [`SOC_RAM_WORDS];
   logic [3:0] byte_v [`SOC_RAM_WORDS];   // Bytes of the model that were written
   data_t      last_tlo;
   logic       have_tlo;
   logic       stalled_q;
   soc_rsp_t   held_q;
   logic       after_rst;
   int         test_errors;

   task automatic report(input string msg);
      $display("ERROR %0t: %s", $time, msg);
      errors_o++;
      test_errors++;
   endtask

   initial begin
      errors_o    = 0;
      tests_o     = 0;
      failed_o    = 0;
      pending_o   = 0;
      test_errors = 0;
      have_tlo    = 1'b0;
      stalled_q   = 1'b0;
      after_rst   = 1'b0;
      for (int i = 0; i < `SOC_RAM_WORDS; i++) byte_v[i] = '0;
   end

   always @(posedge clk_i) begin : watch
      exp_t       e;
      logic [7:0] idx;
      if (rst_ni) begin
         if (!after_rst) begin
            after_rst = 1'b1;
            if (rsp_valid_i || !req_ready_i || timer_irq_i || meip_i || seip_i)
               report("outputs not in reset state after reset");
         end
         // Back-pressure hold
         if (stalled_q && (!rsp_valid_i || rsp_i != held_q))
            report("response changed while stalled");
         if (rsp_valid_i && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
               report("response without a request");
            end else begin
               e = exp_q.pop_front();
               if (rsp_i.err !== e.err)
                  report($sformatf("err %b, expected %b", rsp_i.err, e.err));
               if ((e.chk[0] || (e.chk[1] && e.known)) && rsp_i.rdata !== e.rdata)
                  report($sformatf("rdata %h, expected %h", rsp_i.rdata, e.rdata));
               if (e.chk[2]) begin
                  if (have_tlo && rsp_i.rdata <= last_tlo)
                     report($sformatf("time %h not above %h", rsp_i.rdata, last_tlo));
                  last_tlo = rsp_i.rdata;
                  have_tlo = 1'b1;
               end
            end
         end
         if (req_valid_i && req_ready_i) begin
            idx     = req_i.addr[9:2];
            e.rdata = exp_rdata_i;
            e.err   = exp_err_i;
            e.chk   = chk_i;
            e.known = 1'b1;
            if (chk_i[1]) begin
               e.rdata = ram_m[idx];
               e.known = (byte_v[idx] == 4'hF);
            end
            if (chk_i[3] && {meip_i, seip_i, timer_irq_i} !==
                {exp_meip_i, exp_seip_i, exp_tirq_i})
               report($sformatf("meip/seip/timer %b%b%b, expected %b%b%b",
                  meip_i, seip_i, timer_irq_i, exp_meip_i, exp_seip_i, exp_tirq_i));
            if (req_i.addr[15:12] == `SOC_REG_RAM) begin
               for (int b = 0; b < `SOC_STRB_W; b++) begin
                  if (req_i.strb[b]) begin
                     ram_m[idx][8*b +: 8] = req_i.wdata[8*b +: 8];
                     byte_v[idx][b]       = 1'b1;
                  end
               end
            end
            exp_q.push_back(e);
         end
         stalled_q = rsp_valid_i && !rsp_ready_i;
         held_q    = rsp_i;
      end
      if (test_end_i) begin
         tests_o++;
         if (test_errors != 0) failed_o++;
         $display("Test %0d finished: %0d errors, %s", test_id_i, test_errors,
            (test_errors == 0) ? "ok" : "failed");
         test_errors = 0;
      end
      pending_o <= exp_q.size();
   end

endmodule

// File: tb_soc_fabric.sv
// ------------------------------
// Testbench top for the peripheral fabric
// Applies a stimulus table and lets the checker judge the responses
// ------------------------------
`timescale 1ns/1ns
`include "soc_defs.svh"

module tb_soc_fabric;
   import soc_pkg::*;

   typedef struct {
      int         test;
      addr_t      addr;
      strb_t      strb;
      data_t      wdata;
      irq_t       irq;
      int         gap;     // Idle cycles before the request
      logic       stall;
      logic [3:0] chk;
      data_t      exp_rdata;
      logic       exp_err;
      logic       exp_meip;
      logic       exp_seip;
      logic       exp_tirq;
   } entry_t;

   logic       clk_i;
   logic       rst_ni;
   logic       req_valid_i;
   soc_req_t   req_i;
   logic       req_ready_o;
   logic       rsp_valid_o;
   soc_rsp_t   rsp_o;
   logic       rsp_ready_i;
   irq_t       irq_src_i;
   logic       timer_irq_o;
   logic       meip_o;
   logic       seip_o;
   data_t      exp_rdata;
   logic       exp_err;
   logic       exp_meip;
   logic       exp_seip;
   logic       exp_tirq;
   logic [3:0] chk;
   logic       test_end;
   int         test_id;
   int         pending;
   int         errors;
   int         tests;
   int         failed;
   entry_t     tab[$];
   logic       stall_on;
   logic [31:0] seed = 32'h8f90c3fa;
   int         cycles;
   int         limit;

   soc_fabric_top soc_fabric_top_inst (.*);

   tb_soc_checker checker_inst (
      .clk_i (clk_i), .rst_ni (rst_ni), .req_valid_i (req_valid_i), .req_i (req_i),
      .req_ready_i (req_ready_o), .rsp_valid_i (rsp_valid_o), .rsp_i (rsp_o),
      .rsp_ready_i (rsp_ready_i), .timer_irq_i (timer_irq_o), .meip_i (meip_o),
      .seip_i (seip_o), .exp_rdata_i (exp_rdata), .exp_err_i (exp_err),
      .exp_meip_i (exp_meip), .exp_seip_i (exp_seip), .exp_tirq_i (exp_tirq),
      .chk_i (chk), .test_end_i (test_end), .test_id_i (test_id),
      .pending_o (pending), .errors_o (errors), .tests_o (tests), .failed_o (failed)
   );

   function logic [31:0] next_rand();
      seed ^= seed << 13;
      seed ^= seed >> 17;
      seed ^= seed << 5;
      return seed;
   endfunction

   task automatic add_entry(input int t, input addr_t a, input strb_t s, input data_t d,
                            input irq_t irq, input int gap, input logic [3:0] c,
                            input data_t rd, input logic err, input logic [2:0] lv);
      entry_t e;
      e = '{t, a, s, d, irq, gap, 1'b0, c, rd, err, lv[2], lv[1], lv[0]};
      tab.push_back(e);
   endtask

   // Writes expect zero data, reads use the RAM model
   task automatic ram_access(input int t, input addr_t a, input strb_t s, input data_t d,
                             input logic stall);
      add_entry(t, a, s, d, '0, 0, (s != '0) ? 4'b0001 : 4'b0010, '0, 1'b0, 3'b000);
      tab[$].stall = stall;
   endtask

   task automatic build_table();
      addr_t a [8];
      for (int k = 0; k < 6; k++) begin
         a[k] = {4'h0, 12'(next_rand()) & 12'hFFC};
         ram_access(0, a[k], 4'hF, next_rand(), 1'b0);
      end
      for (int k = 0; k < 6; k++) ram_access(0, a[k], strb_t'(next_rand()) | 4'h1,
                                            next_rand(), 1'b0);
      for (int k = 0; k < 6; k++) ram_access(0, a[k], 4'h0, '0, 1'b0);
      for (int k = 0; k < 8; k++) begin
         a[k] = {4'h0, 12'(next_rand()) & 12'hFFC};
         ram_access(1, a[k], 4'hF, next_rand(), 1'b1);
         ram_access(1, a[k], 4'h0, '0, 1'b1);
      end
      for (int k = 0; k < 8; k++) ram_access(1, a[k], 4'h0, '0, 1'b1);
      // Unmapped regions must not reach the RAM
      add_entry(2, 16'h0010, 4'hF, 32'h11223344, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(2, 16'h3010, 4'hF, 32'hFFFFFFFF, '0, 0, 4'b0001, '0, 1'b1, 3'b000);
      add_entry(2, 16'h9010, 4'hF, 32'hFFFFFFFF, '0, 0, 4'b0001, '0, 1'b1, 3'b000);
      add_entry(2, 16'hF010, 4'hF, 32'hFFFFFFFF, '0, 0, 4'b0001, '0, 1'b1, 3'b000);
      add_entry(2, 16'h5010, 4'h0, '0, '0, 0, 4'b0001, '0, 1'b1, 3'b000);
      add_entry(2, 16'h0010, 4'h0, '0, '0, 0, 4'b0001, 32'h11223344, 1'b0, 3'b000);
      // Timer with compare at reset value
      add_entry(3, 16'h1008, 4'h0, '0, '0, 0, 4'b1001, 32'hFFFFFFFF, 1'b0, 3'b000);
      add_entry(3, 16'h1000, 4'h0, '0, '0, 0, 4'b1100, '0, 1'b0, 3'b000);
      add_entry(3, 16'h1000, 4'h0, '0, '0, 2, 4'b1100, '0, 1'b0, 3'b000);
      add_entry(3, 16'h1004, 4'h0, '0, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      // Compare at zero fires the interrupt
      add_entry(4, 16'h1008, 4'hF, '0, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(4, 16'h100C, 4'hF, '0, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(4, 16'h1008, 4'h0, '0, '0, 3, 4'b1001, '0, 1'b0, 3'b001);
      add_entry(4, 16'h100C, 4'h0, '0, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(4, 16'h100C, 4'h1, 32'hAB, '0, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(4, 16'h100C, 4'h0, '0, '0, 0, 4'b0001, 32'hAB, 1'b0, 3'b000);
      // Enables masking the peripheral lines
      add_entry(5, 16'h2004, 4'h0, '0, 4'hF, 0, 4'b1001, '0, 1'b0, 3'b000);
      add_entry(5, 16'h2004, 4'h1, 32'h2, 4'hA, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(5, 16'h2008, 4'h1, 32'h5, 4'hA, 0, 4'b0001, '0, 1'b0, 3'b000);
      add_entry(5, 16'h2000, 4'h0, '0, 4'hA, 0, 4'b1001, 32'hA, 1'b0, 3'b100);
      add_entry(5, 16'h2004, 4'h0, '0, 4'h5, 0, 4'b1001, 32'h2, 1'b0, 3'b010);
      add_entry(5, 16'h2008, 4'h0, '0, 4'h6, 0, 4'b1001, 32'h5, 1'b0, 3'b110);
   endtask

   task automatic finish_test(input int t);
      req_valid_i <= 1'b0;
      stall_on    <= 1'b0;
      @(posedge clk_i);
      while (pending != 0) @(posedge clk_i);
      test_end <= 1'b1;
      test_id  <= t;
      @(posedge clk_i);
      test_end <= 1'b0;
   endtask

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      rsp_ready_i <= stall_on ? ((next_rand() & 32'h3) != 0) : 1'b1;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout: run did not finish within %0d cycles", limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      rst_ni      = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      rsp_ready_i = 1'b1;
      irq_src_i   = '0;
      exp_rdata   = '0;
      {exp_err, exp_meip, exp_seip, exp_tirq} = '0;
      chk         = '0;
      test_end    = 1'b0;
      test_id     = 0;
      stall_on    = 1'b0;
      cycles      = 0;
      build_table();
      limit = 20 * tab.size() + 100;
      repeat (3) @(posedge clk_i);
      rst_ni <= 1'b1;
      @(posedge clk_i);
      for (int i = 0; i < tab.size(); i++) begin
         if (tab[i].gap > 0) begin
            req_valid_i <= 1'b0;
            repeat (tab[i].gap) @(posedge clk_i);
         end
         stall_on    <= tab[i].stall;
         req_valid_i <= 1'b1;
         req_i       <= '{tab[i].addr, tab[i].strb, tab[i].wdata};
         irq_src_i   <= tab[i].irq;
         chk         <= tab[i].chk;
         exp_rdata   <= tab[i].exp_rdata;
         exp_err     <= tab[i].exp_err;
         exp_meip    <= tab[i].exp_meip;
         exp_seip    <= tab[i].exp_seip;
         exp_tirq    <= tab[i].exp_tirq;
         @(posedge clk_i);
         while (!req_ready_o) @(posedge clk_i);
         if (i == tab.size() - 1 || tab[i+1].test != tab[i].test) finish_test(tab[i].test);
      end
      repeat (2) @(posedge clk_i);
      $display("Tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0 && failed == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
soc_pkg.sv
soc_addr_decode.sv
soc_bram.sv
soc_timer.sv
soc_irq_ctrl.sv
soc_fabric_top.sv
tb_soc_checker.sv
tb_soc_fabric.sv
